// File: rtl/pll_drp_pkg.sv
/*
 * PLL DRP definitions: address map of the six output dividers,
 * divider register layouts and model timing constants
 */
`default_nettype none

package pll_drp_pkg;

	typedef logic [6:0]  drp_addr_t;	// DRP register address
	typedef logic [15:0] drp_data_t;	// DRP data word

	// first divider register of clkout0..clkout5
	localparam drp_addr_t [5:0] CLKOUT_REG1_ADDR = {
		7'h12, 7'h10, 7'h0E, 7'h0C, 7'h0A, 7'h08
	};

	// second register sits right after the first one
	localparam drp_addr_t [5:0] CLKOUT_REG2_ADDR = {
		7'h13, 7'h11, 7'h0F, 7'h0D, 7'h0B, 7'h09
	};

	// divider register 1, counter high/low times
	typedef struct packed {
		logic [2:0] phase_mux;	// coarse phase select, kept on divide change
		logic       reserved;
		logic [5:0] high_time;	// vco cycles high
		logic [5:0] low_time;	// vco cycles low
	} clkout_reg1_t;

	// divider register 2, counter control
	typedef struct packed {
		logic [7:0] reserved;
		logic [1:0] mx;		// must be kept as read
		logic       edge_bit;	// EDGE, half-cycle fix for odd divide
		logic       no_count;	// bypass counter, divide by 1
		logic [3:0] delay_time;	// fine phase delay in vco cycles
	} clkout_reg2_t;

	// one DRP word seen as raw data or as either divider register
	typedef union packed {
		drp_data_t    raw;
		clkout_reg1_t reg1;
		clkout_reg2_t reg2;
	} clkout_word_u;

	localparam int unsigned DRP_READY_LATENCY = 3;	// den to drdy in cycles
	localparam int unsigned LOCK_CYCLES       = 16;	// pll_rst fall to locked

endpackage

`default_nettype wire

// File: rtl/reconfig_pkg.sv
/*
 * Host command channel: opcodes, command and response words
 * and the credit depth of the command buffer
 */
`default_nettype none

package reconfig_pkg;

	typedef enum logic [1:0] {
		READ    = 2'd0,	// read one DRP register
		WRITE   = 2'd1,	// write one DRP register
		SET_DIV = 2'd2	// change divide of one output clock
	} cmd_op_e;

	// command from the host
	typedef struct packed {
		cmd_op_e                op;
		pll_drp_pkg::drp_addr_t addr;		// READ/WRITE only
		pll_drp_pkg::drp_data_t data;		// WRITE only
		logic [2:0]             out_sel;	// SET_DIV output, 0 to 5
		logic [6:0]             divide;		// SET_DIV value, 1 to 64
	} reconfig_cmd_t;

	// response, one per command
	typedef struct packed {
		cmd_op_e                op;
		pll_drp_pkg::drp_data_t data;	// read data, write echo or new reg1
	} reconfig_rsp_t;

	// buffer depth and the host's starting credit count
	localparam int unsigned CMD_CREDITS = 4;

endpackage

`default_nettype wire

// File: rtl/cmd_fifo.sv
/*
 * Command buffer for the credit channel, one credit back per freed entry
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
	input  logic                        drp_clk,
	input  logic                        rst_n,
	input  logic                        cmd_valid,
	input  reconfig_pkg::reconfig_cmd_t cmd,
	output logic                        fifo_valid,
	output reconfig_pkg::reconfig_cmd_t fifo_cmd,
	input  logic                        fifo_pop,
	output logic                        cmd_credit
);
	import reconfig_pkg::*;

	localparam int unsigned PTR_W = $clog2(CMD_CREDITS);
	localparam int unsigned CNT_W = $clog2(CMD_CREDITS + 1);

	reconfig_cmd_t mem [CMD_CREDITS];	// entry storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;		// entries held
	logic             pop;

	assign fifo_valid = (count != '0);
	assign fifo_cmd   = mem[rd_ptr];	// head is always on the output
	assign pop        = fifo_pop & fifo_valid;

	// payload, host never writes without a credit
	always_ff @(posedge drp_clk) begin
		if (cmd_valid)
			mem[wr_ptr] <= cmd;
	end

	always_ff @(posedge drp_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			cmd_credit <= 1'b0;
		end else begin
			cmd_credit <= pop;	// credit in the cycle after the pop
			if (cmd_valid)
				wr_ptr <= (wr_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			case ({cmd_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// idle or push with pop
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_seq.sv
/*
 * Command sequencer: single DRP access for READ/WRITE, and for SET_DIV
 * a read-modify-write of both divider registers under PLL reset
 */
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_seq (
	input  logic                        drp_clk,
	input  logic                        rst_n,
	input  logic                        fifo_valid,
	input  reconfig_pkg::reconfig_cmd_t fifo_cmd,
	output logic                        fifo_pop,
	output logic                        go,
	output logic                        write,
	output pll_drp_pkg::drp_addr_t      addr,
	output pll_drp_pkg::drp_data_t      wdata,
	input  logic                        done,
	input  pll_drp_pkg::drp_data_t      rdata,
	output logic                        pll_rst,
	output logic                        rsp_valid,
	output reconfig_pkg::reconfig_rsp_t rsp
);
	import pll_drp_pkg::*;
	import reconfig_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,		// wait for a command
		S_ISSUE,	// raise go, go was low for this cycle
		S_WAIT		// hold go until done rises
	} seq_state_e;

	seq_state_e    state;
	logic [1:0]    step;		// SET_DIV: rd reg1, wr reg1, rd reg2, wr reg2
	logic          done_q;
	logic          done_rise;
	logic          last_acc;
	reconfig_cmd_t cmd_q;		// command in progress
	clkout_word_u  reg1_q;		// merged reg1, written back in step 1
	clkout_word_u  reg2_q;		// merged reg2, written back in step 3
	clkout_word_u  reg1_new;
	clkout_word_u  reg2_new;
	logic [5:0]    div_low;
	logic [5:0]    div_high;
	drp_data_t     rsp_data;

	assign fifo_pop  = (state == S_IDLE) & fifo_valid;	// take head when idle
	assign done_rise = done & ~done_q;	// done stays high from the last access
	assign last_acc  = (cmd_q.op != SET_DIV) || (step == 2'd3);

	// divide rule
	assign div_low  = cmd_q.divide[6:1];				// divide / 2, rounded down
	assign div_high = 6'(cmd_q.divide - {1'b0, div_low});	// remainder goes high

	// merge new counter fields into the words just read
	always_comb begin
		reg1_new                = rdata;
		reg1_new.reg1.high_time = div_high;
		reg1_new.reg1.low_time  = div_low;
		reg2_new                = rdata;
		reg2_new.reg2.edge_bit  = cmd_q.divide[0];		// odd divide
		reg2_new.reg2.no_count  = (cmd_q.divide == 7'd1);	// bypass for /1
	end

	// access decode, stable while go is held
	always_comb begin
		write = 1'b0;
		addr  = cmd_q.addr;
		wdata = cmd_q.data;
		case (cmd_q.op)
			WRITE:   write = 1'b1;
			SET_DIV: begin
				write = step[0];	// odd steps write back
				addr  = step[1] ? CLKOUT_REG2_ADDR[cmd_q.out_sel]
				                : CLKOUT_REG1_ADDR[cmd_q.out_sel];
				wdata = step[1] ? reg2_q.raw : reg1_q.raw;
			end
			default: write = 1'b0;	// READ
		endcase
	end

	always_comb begin
		case (cmd_q.op)
			READ:    rsp_data = rdata;
			WRITE:   rsp_data = cmd_q.data;	// echo
			default: rsp_data = reg1_q.raw;	// SET_DIV reports new reg1
		endcase
	end

	// control
	always_ff @(posedge drp_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			step      <= 2'd0;
			go        <= 1'b0;
			pll_rst   <= 1'b0;
			rsp_valid <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q    <= done;
			rsp_valid <= 1'b0;
			case (state)
				S_IDLE: if (fifo_valid) begin
					step    <= 2'd0;
					pll_rst <= (fifo_cmd.op == SET_DIV);	// reset before first access
					state   <= S_ISSUE;
				end
				S_ISSUE: begin
					go    <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: if (done_rise) begin
					go <= 1'b0;
					if (last_acc) begin
						pll_rst   <= 1'b0;	// released together with the response
						rsp_valid <= 1'b1;
						state     <= S_IDLE;
					end else begin
						step  <= step + 1'b1;
						state <= S_ISSUE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload
	always_ff @(posedge drp_clk) begin
		if (fifo_pop)
			cmd_q <= fifo_cmd;
		if (state == S_WAIT && done_rise) begin
			if (cmd_q.op == SET_DIV && step == 2'd0)
				reg1_q <= reg1_new;
			if (cmd_q.op == SET_DIV && step == 2'd2)
				reg2_q <= reg2_new;
			rsp.op   <= cmd_q.op;
			rsp.data <= rsp_data;	// only taken with rsp_valid
		end
	end

endmodule

`default_nettype wire

// File: rtl/pll_drp_port.sv
/*
 * DRP handshake: go edge to one-cycle den, done and read data on drdy
 */
`timescale 1ns/1ps
`default_nettype none

module pll_drp_port (
	input  logic                   drp_clk,
	input  logic                   rst_n,
	input  logic                   go,
	input  logic                   write,
	input  pll_drp_pkg::drp_addr_t addr,
	input  pll_drp_pkg::drp_data_t wdata,
	output logic                   done,
	output pll_drp_pkg::drp_data_t rdata,
	output logic                   den,
	output logic                   dwe,
	output pll_drp_pkg::drp_addr_t daddr,
	output pll_drp_pkg::drp_data_t di,
	input  logic                   drdy,
	input  pll_drp_pkg::drp_data_t dout
);

	logic go_q;	// go one cycle late

	// held by the sequencer for the whole access
	assign dwe   = write;
	assign daddr = addr;
	assign di    = wdata;

	always_ff @(posedge drp_clk or negedge rst_n) begin
		if (!rst_n) begin
			go_q <= 1'b0;
			den  <= 1'b0;
			done <= 1'b0;
		end else begin
			go_q <= go;
			den  <= go & ~go_q;	// rising edge of go
			if (drdy)
				done <= 1'b1;
			else if (den)
				done <= 1'b0;	// new access started
		end
	end

	always_ff @(posedge drp_clk) begin
		if (drdy)
			rdata <= dout;
	end

endmodule

`default_nettype wire

// File: rtl/pll_drp_regs.sv
/*
 * PLL DRP register space model with fixed ready latency and lock timing
 */
`timescale 1ns/1ps
`default_nettype none

module pll_drp_regs (
	input  logic                   drp_clk,
	input  logic                   rst_n,
	input  logic                   den,
	input  logic                   dwe,
	input  pll_drp_pkg::drp_addr_t daddr,
	input  pll_drp_pkg::drp_data_t di,
	output logic                   drdy,
	output pll_drp_pkg::drp_data_t dout,
	input  logic                   pll_rst,
	output logic                   locked
);
	import pll_drp_pkg::*;

	localparam int unsigned DLY_W  = $clog2(DRP_READY_LATENCY + 1);
	localparam int unsigned LOCK_W = $clog2(LOCK_CYCLES + 1);

	drp_data_t         mem [128];	// full 7-bit address space
	logic [DLY_W-1:0]  dly_cnt;		// cycles left until drdy
	logic [LOCK_W-1:0] lock_cnt;	// cycles since pll_rst fell

	assign drdy   = (dly_cnt == DLY_W'(1));
	assign locked = ~pll_rst & (lock_cnt == LOCK_W'(LOCK_CYCLES));	// drops with pll_rst

	// access happens at den, dout holds until the next one
	always_ff @(posedge drp_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 128; i++)
				mem[i] <= '0;
			dout <= '0;
		end else if (den) begin
			if (dwe)
				mem[daddr] <= di;
			dout <= mem[daddr];	// old value on a write
		end
	end

	always_ff @(posedge drp_clk or negedge rst_n) begin
		if (!rst_n) begin
			dly_cnt  <= '0;
			lock_cnt <= '0;	// lock count starts at reset release
		end else begin
			if (den)
				dly_cnt <= DLY_W'(DRP_READY_LATENCY);
			else if (dly_cnt != '0)
				dly_cnt <= dly_cnt - 1'b1;
			if (pll_rst)
				lock_cnt <= '0;
			else if (lock_cnt != LOCK_W'(LOCK_CYCLES))
				lock_cnt <= lock_cnt + 1'b1;	// saturates when locked
		end
	end

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_top.sv
/*
 * PLL reconfiguration subsystem: command buffer, sequencer, DRP port
 * and DRP register model
 */
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_top (
	input  logic                        drp_clk,
	input  logic                        rst_n,
	input  logic                        cmd_valid,
	input  reconfig_pkg::reconfig_cmd_t cmd,
	output logic                        cmd_credit,
	output logic                        rsp_valid,
	output reconfig_pkg::reconfig_rsp_t rsp,
	output logic                        locked
);
	import pll_drp_pkg::*;
	import reconfig_pkg::*;

	logic          fifo_valid;
	reconfig_cmd_t fifo_cmd;
	logic          fifo_pop;
	logic          go;		// sequencer access request
	logic          write;
	drp_addr_t     addr;
	drp_data_t     wdata;
	logic          done;
	drp_data_t     rdata;
	logic          pll_rst;
	logic          den;		// DRP bus
	logic          dwe;
	drp_addr_t     daddr;
	drp_data_t     di;
	logic          drdy;
	drp_data_t     dout;

	cmd_fifo i_cmd_fifo (
		.drp_clk, .rst_n, .cmd_valid, .cmd,
		.fifo_valid, .fifo_cmd, .fifo_pop, .cmd_credit
	);

	pll_reconfig_seq i_pll_reconfig_seq (
		.drp_clk, .rst_n, .fifo_valid, .fifo_cmd, .fifo_pop,
		.go, .write, .addr, .wdata, .done, .rdata,
		.pll_rst, .rsp_valid, .rsp
	);

	pll_drp_port i_pll_drp_port (
		.drp_clk, .rst_n, .go, .write, .addr, .wdata, .done, .rdata,
		.den, .dwe, .daddr, .di, .drdy, .dout
	);

	// stands in for the vendor PLL primitive
	pll_drp_regs i_pll_drp_regs (
		.drp_clk, .rst_n, .den, .dwe, .daddr, .di,
		.drdy, .dout, .pll_rst, .locked
	);

endmodule

`default_nettype wire

// File: dv/tb_pll_reconfig.sv
/*
 * Testbench for the PLL reconfiguration subsystem with a credit-limited host,
 * a shadow DRP register space and in-order response checking
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pll_reconfig;
	import pll_drp_pkg::*;
	import reconfig_pkg::*;

	localparam int unsigned TIMEOUT_CYCLES = 1000;	// bound for credit and response waits
	localparam int unsigned LOCK_WAIT      = LOCK_CYCLES + 8;	// bound for lock changes

	logic          drp_clk;
	logic          rst_n;
	logic          cmd_valid;
	reconfig_cmd_t cmd;
	logic          cmd_credit;
	logic          rsp_valid;
	reconfig_rsp_t rsp;
	logic          locked;

	drp_data_t     shadow [128];	// expected DRP register contents
	reconfig_rsp_t exp_q [$];		// responses still to come, in command order
	reconfig_rsp_t exp_rsp;
	int            credits;		// host view of free FIFO entries

	pll_reconfig_top i_pll_reconfig_top (
		.drp_clk, .rst_n, .cmd_valid, .cmd, .cmd_credit, .rsp_valid, .rsp, .locked
	);

	initial begin
		drp_clk = 1'b0;
		forever #4 drp_clk = ~drp_clk;	// 8 ns period
	end

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s, stopped at %0t ns", msg, $time);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input reconfig_rsp_t got, input reconfig_rsp_t exp);
		if (got !== exp)
			report_mismatch($sformatf("response op %0d data %04h, expected op %0d data %04h",
				got.op, got.data, exp.op, exp.data));
	endtask

	task automatic check_locked(input logic got, input logic exp, input string when);
		if (got !== exp)
			report_mismatch($sformatf("locked is %b %s, expected %b", got, when, exp));
	endtask

	// applies one command to the shadow and gives the response it must produce
	function automatic reconfig_rsp_t predict_rsp(input reconfig_cmd_t c);
		reconfig_rsp_t r;
		clkout_reg1_t  r1;
		clkout_reg2_t  r2;
		drp_addr_t     a1;
		logic [6:0]    low;
		logic [6:0]    high;
		r.op = c.op;
		case (c.op)
			READ:  r.data = shadow[c.addr];
			WRITE: begin
				shadow[c.addr] = c.data;
				r.data         = c.data;	// write echo
			end
			default: begin
				a1          = 7'h08 + {c.out_sel, 1'b0};	// reg1 pairs start at 08
				low         = c.divide / 2;
				high        = c.divide - low;
				r1          = shadow[a1];	// phase_mux and reserved stay
				r1.high_time = high[5:0];
				r1.low_time  = low[5:0];
				r2          = shadow[a1 + 7'd1];	// mx and delay_time stay
				r2.edge_bit = (c.divide % 2) == 1;
				r2.no_count = (c.divide == 7'd1);
				shadow[a1]         = r1;
				shadow[a1 + 7'd1] = r2;
				r.data             = r1;
			end
		endcase
		return r;
	endfunction

	function automatic reconfig_cmd_t make_cmd(input cmd_op_e op, input drp_addr_t addr,
		input drp_data_t data, input logic [2:0] out_sel, input logic [6:0] divide);
		reconfig_cmd_t c;
		c.op      = op;
		c.addr    = addr;
		c.data    = data;
		c.out_sel = out_sel;
		c.divide  = divide;
		return c;
	endfunction

	// one command cycle once a credit is in hand
	task automatic send_cmd(input reconfig_cmd_t c);
		int unsigned n;
		n = 0;
		while (credits == 0) begin
			if (n == TIMEOUT_CYCLES)
				abort_run("no command credit came back");
			@(posedge drp_clk);
			#1;
			n++;
		end
		cmd_valid = 1'b1;
		cmd       = c;
		credits--;
		exp_q.push_back(predict_rsp(c));
		@(posedge drp_clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_locked(input logic val, input string what);
		int unsigned n;
		n = 0;
		while (locked !== val) begin
			if (n == LOCK_WAIT)
				abort_run($sformatf("locked never went to %b while waiting for %s", val, what));
			@(posedge drp_clk);
			#1;
			n++;
		end
	endtask

	task automatic wait_all_rsp();
		int unsigned n;
		n = 0;
		while (exp_q.size() != 0) begin
			if (n == TIMEOUT_CYCLES)
				abort_run($sformatf("%0d responses never arrived", exp_q.size()));
			@(posedge drp_clk);
			#1;
			n++;
		end
	endtask

	// checks responses and counts returned credits on the falling edge
	always @(negedge drp_clk) begin
		if (rst_n) begin
			if (cmd_credit)
				credits++;
			if (credits > int'(CMD_CREDITS))
				report_mismatch($sformatf("credit count %0d above %0d", credits, CMD_CREDITS));
			if (rsp_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("a response came with no command outstanding");
				end else begin
					exp_rsp = exp_q.pop_front();
					check_rsp(rsp, exp_rsp);
					if (rsp.op == SET_DIV)
						check_locked(locked, 1'b0, "at the SET_DIV response");	// pll_rst just fell
				end
			end
		end
	end

	initial begin
		int unsigned a;
		drp_data_t   d;
		logic [6:0]  div;
		void'($urandom(32'h6efff222));
		rst_n     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		credits   = CMD_CREDITS;
		for (int i = 0; i < 128; i++)
			shadow[i] = '0;	// model clears on reset
		repeat (3) @(posedge drp_clk);
		#1;
		rst_n = 1'b1;
		check_locked(locked, 1'b0, "right after reset");

		// lock after reset and reads of the cleared space
		wait_locked(1'b1, "lock after reset");
		repeat (8) send_cmd(make_cmd(READ, drp_addr_t'($urandom_range(0, 127)), '0, '0, '0));
		wait_all_rsp();

		// write then read back
		for (int i = 0; i < 8; i++) begin
			a = $urandom_range(0, 127);
			d = drp_data_t'($urandom);
			send_cmd(make_cmd(WRITE, drp_addr_t'(a), d, '0, '0));
			send_cmd(make_cmd(READ, drp_addr_t'(a), '0, '0, '0));
		end
		wait_all_rsp();

		// SET_DIV on every output over presets with random kept fields
		for (int o = 0; o < 6; o++) begin
			for (int k = 0; k < 4; k++) begin
				case (k)
					0:       div = 7'd1;
					1:       div = 7'd2;
					2:       div = 7'(2 * $urandom_range(1, 31) + 1);	// odd 3..63
					default: div = (o == 0) ? 7'd64 : 7'(2 * $urandom_range(2, 32));
				endcase
				a = 8 + 2 * o;
				send_cmd(make_cmd(WRITE, drp_addr_t'(a), drp_data_t'($urandom), '0, '0));
				send_cmd(make_cmd(WRITE, drp_addr_t'(a + 1), drp_data_t'($urandom), '0, '0));
				send_cmd(make_cmd(SET_DIV, '0, '0, 3'(o), div));
				send_cmd(make_cmd(READ, drp_addr_t'(a + 1), '0, '0, '0));	// reg2 readback
			end
		end
		wait_all_rsp();

		// lock drops during SET_DIV and comes back after the response
		wait_locked(1'b1, "lock before SET_DIV");
		send_cmd(make_cmd(SET_DIV, '0, '0, 3'd2, 7'd5));
		wait_locked(1'b0, "lock loss during SET_DIV");
		wait_all_rsp();
		wait_locked(1'b1, "lock after SET_DIV");

		// back-to-back burst limited by credits
		for (int i = 0; i < 6; i++) begin
			a = $urandom_range(0, 127);
			if (i == 2)
				send_cmd(make_cmd(SET_DIV, '0, '0, 3'($urandom_range(0, 5)), 7'd9));
			else if (i % 2 == 0)
				send_cmd(make_cmd(WRITE, drp_addr_t'(a), drp_data_t'($urandom), '0, '0));
			else
				send_cmd(make_cmd(READ, drp_addr_t'(a), '0, '0, '0));
		end
		wait_all_rsp();
		if (credits != int'(CMD_CREDITS))
			report_mismatch($sformatf("%0d credits after the burst, expected %0d",
				credits, CMD_CREDITS));

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
rtl/pll_drp_pkg.sv
rtl/reconfig_pkg.sv
rtl/cmd_fifo.sv
rtl/pll_reconfig_seq.sv
rtl/pll_drp_port.sv
rtl/pll_drp_regs.sv
rtl/pll_reconfig_top.sv
dv/tb_pll_reconfig.sv

// File: Bender.yml
package:
  name: pll_reconfig

sources:
  - files:
      - rtl/pll_drp_pkg.sv
      - rtl/reconfig_pkg.sv
      - rtl/cmd_fifo.sv
      - rtl/pll_reconfig_seq.sv
      - rtl/pll_drp_port.sv
      - rtl/pll_drp_regs.sv
      - rtl/pll_reconfig_top.sv
  - target: test
    files:
      - dv/tb_pll_reconfig.sv
